//--- sources.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/rename_ifs.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/reorder_buffer.sv
verilog/arch_map.sv
verilog/rename_core.sv
testbench/tb_clock.sv
testbench/tb_rename_core.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the rename core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rename_core -f sources.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_rename_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1

//--- testbench/tb_rename_core.sv
/*
 * rename core testbench: reference model of map, free queue and rob,
 * directed tests, random mix, timeout and summary
 */

`timescale 1ns/1ps
`include "rename_consts.svh"

module tb_rename_core;
  import rename_pkg::*;

  localparam int RANDOM_CYCLES = 200;
  // directed tests need about 150 cycles and the total gets double margin
  localparam int TIMEOUT_CYCLES = 2 * (RANDOM_CYCLES + 150);

  logic      clock;
  logic      reset;
  logic      dispatch_valid;
  logic      dispatch_ready;
  arch_reg_t dispatch_dest;
  arch_reg_t dispatch_src_a;
  arch_reg_t dispatch_src_b;
  phys_tag_t dest_tag;
  phys_tag_t old_tag;
  phys_tag_t src_a_tag;
  logic      src_a_ready;
  phys_tag_t src_b_tag;
  logic      src_b_ready;
  logic      cdb_valid;
  phys_tag_t cdb_tag;
  logic      retire_valid;
  arch_reg_t retire_arch;
  phys_tag_t retire_tag;
  phys_tag_t retire_old_tag;
  arch_reg_t arch_read_idx;
  phys_tag_t arch_read_tag;

  tb_clock u_tb_clock (.clock, .reset);

  rename_core u_rename_core (.*);

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  phys_tag_t m_map      [`NUM_ARCH_REGS];
  phys_tag_t m_arch_map [`NUM_ARCH_REGS];
  logic      m_ready    [`NUM_PHYS_REGS];
  phys_tag_t m_free     [$];
  // in-order buffer as one queue per field
  arch_reg_t rob_arch   [$];
  phys_tag_t rob_tag    [$];
  phys_tag_t rob_old    [$];
  logic      rob_done   [$];

  int        errors = 0;
  int        checks = 0;
  int        cycles = 0;
  int        seed   = 32'h389b_0efb;
  // dut values seen in the last checked cycle
  phys_tag_t seen_dest_tag;
  logic      seen_ready;

  task automatic reset_model();
    for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
      m_map[i]      = phys_tag_t'(i);
      m_arch_map[i] = phys_tag_t'(i);
    end
    for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
      m_ready[i] = 1'b1;
    end
    // spare tags in ascending order
    for (int i = `NUM_ARCH_REGS; i < `NUM_PHYS_REGS; i++) begin
      m_free.push_back(phys_tag_t'(i));
    end
  endtask

  function automatic int count_pending();
    int n;
    n = 0;
    foreach (rob_done[i]) begin
      if (!rob_done[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  // tag of the k-th entry still waiting for completion
  function automatic phys_tag_t pending_tag(input int k);
    int n;
    n = 0;
    foreach (rob_done[i]) begin
      if (!rob_done[i]) begin
        if (n == k) begin
          return rob_tag[i];
        end
        n++;
      end
    end
    return '0;
  endfunction

  // one rising edge of the model from the pre-edge state
  task automatic update_model(input logic dv, input arch_reg_t dest,
                              input logic cv, input phys_tag_t ct);
    logic      fire;
    logic      retire;
    phys_tag_t new_tag;
    fire   = dv && (rob_tag.size() < `ROB_DEPTH) && (m_free.size() > 0);
    retire = (rob_tag.size() > 0) && rob_done[0];
    if (cv) begin
      m_ready[ct] = 1'b1;
      foreach (rob_tag[i]) begin
        if (!rob_done[i] && rob_tag[i] == ct) begin
          rob_done[i] = 1'b1;
        end
      end
    end
    if (retire) begin
      m_arch_map[rob_arch[0]] = rob_tag[0];
      m_free.push_back(rob_old[0]);
      void'(rob_arch.pop_front());
      void'(rob_tag.pop_front());
      void'(rob_old.pop_front());
      void'(rob_done.pop_front());
    end
    if (fire) begin
      new_tag = m_free.pop_front();
      rob_arch.push_back(dest);
      rob_tag.push_back(new_tag);
      rob_old.push_back(m_map[dest]);
      rob_done.push_back(1'b0);
      m_map[dest]      = new_tag;
      m_ready[new_tag] = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks and cycle driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs(input arch_reg_t dest, input arch_reg_t a,
                               input arch_reg_t b, input arch_reg_t ri);
    logic exp_ready;
    logic exp_retire;
    exp_ready  = (rob_tag.size() < `ROB_DEPTH) && (m_free.size() > 0);
    exp_retire = (rob_tag.size() > 0) && rob_done[0];
    check_eq("dispatch_ready", dispatch_ready, exp_ready);
    // dest_tag is meaningless with no free tag
    if (m_free.size() > 0) begin
      check_eq("dest_tag", dest_tag, m_free[0]);
    end
    check_eq("old_tag", old_tag, m_map[dest]);
    check_eq("src_a_tag", src_a_tag, m_map[a]);
    check_eq("src_a_ready", src_a_ready, m_ready[m_map[a]]);
    check_eq("src_b_tag", src_b_tag, m_map[b]);
    check_eq("src_b_ready", src_b_ready, m_ready[m_map[b]]);
    check_eq("retire_valid", retire_valid, exp_retire);
    if (exp_retire) begin
      check_eq("retire_arch", retire_arch, rob_arch[0]);
      check_eq("retire_tag", retire_tag, rob_tag[0]);
      check_eq("retire_old_tag", retire_old_tag, rob_old[0]);
    end
    check_eq("arch_read_tag", arch_read_tag, m_arch_map[ri]);
  endtask

  // drive at this edge and check mid-cycle then step the model at the next edge
  task automatic run_cycle(input logic dv, input arch_reg_t dest, input arch_reg_t a,
                           input arch_reg_t b, input logic cv, input phys_tag_t ct,
                           input arch_reg_t ri);
    dispatch_valid <= dv;
    dispatch_dest  <= dest;
    dispatch_src_a <= a;
    dispatch_src_b <= b;
    cdb_valid      <= cv;
    cdb_tag        <= ct;
    arch_read_idx  <= ri;
    @(negedge clock);
    check_outputs(dest, a, b, ri);
    seen_dest_tag = dest_tag;
    seen_ready    = dispatch_ready;
    @(posedge clock);
    update_model(dv, dest, cv, ct);
  endtask

  // complete everything in flight and let it retire
  task automatic drain(input arch_reg_t ri);
    while (rob_tag.size() > 0) begin
      if (count_pending() > 0) begin
        run_cycle(1'b0, '0, '0, '0, 1'b1, pending_tag(0), ri);
      end else begin
        run_cycle(1'b0, '0, '0, '0, 1'b0, '0, ri);
      end
    end
  endtask

  task automatic report(input string name, input int errors_before);
    $display("test %-10s done, %0d errors", name, errors - errors_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int e0;
    e0 = errors;
    for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
      run_cycle(1'b0, arch_reg_t'(i), arch_reg_t'(i), arch_reg_t'(7 - i), 1'b0, '0,
                arch_reg_t'(i));
    end
    report("reset", e0);
  endtask

  task automatic test_rename();
    int e0;
    e0 = errors;
    // reg 1 renamed twice so the second sees the first as old tag
    run_cycle(1'b1, 3'd1, 3'd0, 3'd2, 1'b0, '0, 3'd1);
    run_cycle(1'b1, 3'd2, 3'd1, 3'd3, 1'b0, '0, 3'd1);
    run_cycle(1'b1, 3'd1, 3'd1, 3'd2, 1'b0, '0, 3'd1);
    // ready shows one cycle after the strobe since there is no bypass
    run_cycle(1'b0, 3'd0, 3'd1, 3'd2, 1'b1, rob_tag[2], 3'd1);
    run_cycle(1'b0, 3'd0, 3'd1, 3'd2, 1'b0, '0, 3'd1);
    drain(3'd1);
    report("rename", e0);
  endtask

  task automatic test_in_order();
    int        e0;
    phys_tag_t tags [4];
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      run_cycle(1'b1, arch_reg_t'(3 + i), arch_reg_t'(i), arch_reg_t'(i + 1), 1'b0, '0, 3'd3);
    end
    foreach (tags[i]) begin
      tags[i] = rob_tag[i];
    end
    // youngest first so nothing retires until the oldest is done
    for (int i = 3; i >= 0; i--) begin
      run_cycle(1'b0, '0, 3'd3, 3'd4, 1'b1, tags[i], arch_reg_t'(3 + i));
    end
    drain(3'd4);
    report("in_order", e0);
  endtask

  task automatic test_full_stall();
    int        e0;
    phys_tag_t first_old;
    e0 = errors;
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      run_cycle(1'b1, arch_reg_t'(i), arch_reg_t'(i), 3'd7, 1'b0, '0, arch_reg_t'(i));
    end
    // ninth request held while the buffer is full
    repeat (2) run_cycle(1'b1, 3'd5, 3'd1, 3'd2, 1'b0, '0, 3'd5);
    first_old = rob_old[0];
    run_cycle(1'b1, 3'd5, 3'd1, 3'd2, 1'b1, rob_tag[0], 3'd5);
    run_cycle(1'b1, 3'd5, 3'd1, 3'd2, 1'b0, '0, 3'd0);
    run_cycle(1'b1, 3'd5, 3'd1, 3'd2, 1'b0, '0, 3'd0);
    check_eq("ninth accepted", seen_ready, 1);
    check_eq("ninth dest_tag", seen_dest_tag, first_old);
    drain(3'd5);
    report("full_stall", e0);
  endtask

  task automatic test_committed();
    int e0;
    e0 = errors;
    // speculative renames leave the committed map alone
    run_cycle(1'b1, 3'd2, 3'd0, 3'd0, 1'b0, '0, 3'd2);
    run_cycle(1'b1, 3'd5, 3'd2, 3'd5, 1'b0, '0, 3'd2);
    run_cycle(1'b0, '0, 3'd2, 3'd5, 1'b1, rob_tag[0], 3'd2);
    run_cycle(1'b0, '0, 3'd2, 3'd5, 1'b1, rob_tag[1], 3'd2);
    run_cycle(1'b0, '0, 3'd2, 3'd5, 1'b0, '0, 3'd2);
    run_cycle(1'b0, '0, 3'd2, 3'd5, 1'b0, '0, 3'd5);
    drain(3'd5);
    report("committed", e0);
  endtask

  task automatic test_random();
    int        e0;
    logic      dv;
    logic      cv;
    logic      held;
    arch_reg_t d;
    arch_reg_t a;
    arch_reg_t b;
    arch_reg_t ri;
    phys_tag_t ct;
    e0   = errors;
    held = 1'b0;
    dv   = 1'b0;
    d    = '0;
    a    = '0;
    b    = '0;
    ri   = '0;
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      // a stalled request keeps its fields
      if (!held) begin
        dv = ($random(seed) & 1) != 0;
        d  = arch_reg_t'($random(seed));
        a  = arch_reg_t'($random(seed));
        b  = arch_reg_t'($random(seed));
      end
      ri = arch_reg_t'($random(seed));
      cv = 1'b0;
      ct = '0;
      if (count_pending() > 0 && ($random(seed) & 1) != 0) begin
        cv = 1'b1;
        ct = pending_tag($unsigned($random(seed)) % count_pending());
      end
      held = dv && !((rob_tag.size() < `ROB_DEPTH) && (m_free.size() > 0));
      run_cycle(dv, d, a, b, cv, ct, ri);
    end
    // a stalled request stays up until the buffer takes it
    while (held) begin
      held = !((rob_tag.size() < `ROB_DEPTH) && (m_free.size() > 0));
      cv   = count_pending() > 0;
      ct   = '0;
      if (cv) begin
        ct = pending_tag(0);
      end
      run_cycle(1'b1, d, a, b, cv, ct, ri);
    end
    drain(3'd0);
    report("random", e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    dispatch_valid = 1'b0;
    dispatch_dest  = '0;
    dispatch_src_a = '0;
    dispatch_src_b = '0;
    cdb_valid      = 1'b0;
    cdb_tag        = '0;
    arch_read_idx  = '0;
    reset_model();
    @(negedge reset);
    @(posedge clock);
    test_reset();
    test_rename();
    test_in_order();
    test_full_stall();
    test_committed();
    test_random();
    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clock.sv
/*
 * testbench clock and reset generator
 */

`timescale 1ns/1ps

module tb_clock (
  output logic clock,
  output logic reset
);

  // 8 ns period
  localparam int HALF_PERIOD = 4;

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  // reset held over the first three rising edges
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

//--- verilog/rename_core.sv
/*
 * top of the rename core: map table, free list, rob, arch map
 */

`timescale 1ns/1ps

module rename_core (
  input  logic                  clock,
  input  logic                  reset,

  // dispatch
  input  logic                  dispatch_valid,
  output logic                  dispatch_ready,
  input  rename_pkg::arch_reg_t dispatch_dest,
  input  rename_pkg::arch_reg_t dispatch_src_a,
  input  rename_pkg::arch_reg_t dispatch_src_b,

  // rename results
  output rename_pkg::phys_tag_t dest_tag,
  output rename_pkg::phys_tag_t old_tag,
  output rename_pkg::phys_tag_t src_a_tag,
  output logic                  src_a_ready,
  output rename_pkg::phys_tag_t src_b_tag,
  output logic                  src_b_ready,

  // completion strobe
  input  logic                  cdb_valid,
  input  rename_pkg::phys_tag_t cdb_tag,

  // retirement
  output logic                  retire_valid,
  output rename_pkg::arch_reg_t retire_arch,
  output rename_pkg::phys_tag_t retire_tag,
  output rename_pkg::phys_tag_t retire_old_tag,

  // committed map read
  input  rename_pkg::arch_reg_t arch_read_idx,
  output rename_pkg::phys_tag_t arch_read_tag
);

  dispatch_if disp_bus ();
  retire_if   ret_bus ();

  logic free_empty;

  ////////////////////////////////////////////////////////////////////////////
  // bus to port wiring
  ////////////////////////////////////////////////////////////////////////////

  assign disp_bus.dest_arch = dispatch_dest;
  assign dest_tag           = disp_bus.new_tag;
  assign old_tag            = disp_bus.old_tag;

  assign retire_valid   = ret_bus.retire_valid;
  assign retire_arch    = ret_bus.retire_arch;
  assign retire_tag     = ret_bus.retire_tag;
  assign retire_old_tag = ret_bus.retire_old_tag;

  ////////////////////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////////////////////

  map_table u_map_table (
    .clock, .reset,
    .src_a (dispatch_src_a), .src_b (dispatch_src_b),
    .src_a_tag, .src_b_tag, .src_a_ready, .src_b_ready,
    .cdb_valid, .cdb_tag,
    .disp  (disp_bus.renamer)
  );

  free_list u_free_list (
    .clock, .reset,
    .alloc (disp_bus.allocator),
    .free  (ret_bus.commit),
    .empty (free_empty)
  );

  reorder_buffer u_reorder_buffer (
    .clock, .reset,
    .dispatch_valid, .dispatch_ready,
    .free_empty,
    .disp      (disp_bus.tracker),
    .dest_arch (dispatch_dest),
    .dest_tag  (disp_bus.new_tag),
    .old_tag   (disp_bus.old_tag),
    .cdb_valid, .cdb_tag,
    .ret       (ret_bus.source)
  );

  arch_map u_arch_map (
    .clock, .reset,
    .ret (ret_bus.commit),
    .arch_read_idx, .arch_read_tag
  );

endmodule

//--- verilog/arch_map.sv
/*
 * committed arch-to-physical map with a read port
 */

`timescale 1ns/1ps
`include "rename_consts.svh"

module arch_map (
  input  logic                  clock,
  input  logic                  reset,
  retire_if.commit              ret,
  input  rename_pkg::arch_reg_t arch_read_idx,
  output rename_pkg::phys_tag_t arch_read_tag
);
  import rename_pkg::*;

  // only retired instructions land here
  phys_tag_t map [`NUM_ARCH_REGS];

  // committed state lookup
  assign arch_read_tag = map[arch_read_idx];

  ////////////////////////////////////////////////////////////////////////////
  // retirement write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // reg i lives in tag i out of reset
      for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
        map[i] <= phys_tag_t'(i);
      end
    end else if (ret.retire_valid) begin
      map[ret.retire_arch] <= ret.retire_tag;
    end
  end

  // the tag being freed must be the one this reg was committed to
  assert property (@(posedge clock) disable iff (reset)
    ret.retire_valid |-> map[ret.retire_arch] == ret.retire_old_tag);

endmodule

//--- verilog/reorder_buffer.sv
/*
 * reorder buffer: in-order queue of renamed instructions
 * cdb completion marking, head retirement, dispatch handshake
 */

`timescale 1ns/1ps
`include "rename_consts.svh"

module reorder_buffer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  output logic                  dispatch_ready,
  input  logic                  free_empty,
  dispatch_if.tracker           disp,
  input  rename_pkg::arch_reg_t dest_arch,
  input  rename_pkg::phys_tag_t dest_tag,
  input  rename_pkg::phys_tag_t old_tag,
  input  logic                  cdb_valid,
  input  rename_pkg::phys_tag_t cdb_tag,
  retire_if.source              ret
);
  import rename_pkg::*;

  localparam int IDX_W = $clog2(`ROB_DEPTH);

  // entry payload, no reset
  arch_reg_t  ent_arch    [`ROB_DEPTH];
  phys_tag_t  ent_tag     [`ROB_DEPTH];
  phys_tag_t  ent_old_tag [`ROB_DEPTH];
  // entry control
  rob_state_e ent_state   [`ROB_DEPTH];

  rob_ptr_t         head;
  rob_ptr_t         tail;
  logic [IDX_W-1:0] head_idx;
  logic [IDX_W-1:0] tail_idx;
  logic             full;
  logic             empty;
  logic             retire;
  logic [`ROB_DEPTH-1:0] cdb_match;

  assign head_idx = head[IDX_W-1:0];
  assign tail_idx = tail[IDX_W-1:0];

  // same slot, wrap bits tell full from empty
  assign empty = (head == tail);
  assign full  = (head_idx == tail_idx) && (head[IDX_W] != tail[IDX_W]);

  ////////////////////////////////////////////////////////////////////////////
  // dispatch handshake
  ////////////////////////////////////////////////////////////////////////////

  assign dispatch_ready     = !full && !free_empty;
  assign disp.dispatch_fire = dispatch_valid && dispatch_ready;

  ////////////////////////////////////////////////////////////////////////////
  // completion cam and retirement
  ////////////////////////////////////////////////////////////////////////////

  // compare the cdb tag against every pending slot
  always_comb begin
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      cdb_match[i] = (ent_state[i] == ENTRY_PENDING) && (ent_tag[i] == cdb_tag);
    end
  end

  // head done means retire now, no back-pressure
  assign retire             = (ent_state[head_idx] == ENTRY_DONE);
  assign ret.retire_valid   = retire;
  assign ret.retire_arch    = ent_arch[head_idx];
  assign ret.retire_tag     = ent_tag[head_idx];
  assign ret.retire_old_tag = ent_old_tag[head_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        ent_state[i] <= ENTRY_FREE;
      end
    end else begin
      // mark completed
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        if (cdb_valid && cdb_match[i]) begin
          ent_state[i] <= ENTRY_DONE;
        end
      end
      // pop the head
      if (retire) begin
        ent_state[head_idx] <= ENTRY_FREE;
        head                <= head + 1'b1;
      end
      // push at the tail, never the head slot here since full blocks dispatch
      if (disp.dispatch_fire) begin
        ent_arch[tail_idx]    <= dest_arch;
        ent_tag[tail_idx]     <= dest_tag;
        ent_old_tag[tail_idx] <= old_tag;
        ent_state[tail_idx]   <= ENTRY_PENDING;
        tail                  <= tail + 1'b1;
      end
    end
  end

  // each broadcast tag belongs to exactly one in-flight instruction
  assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> $onehot(cdb_match));

  // the head can only be retired out of a non-empty buffer
  assert property (@(posedge clock) disable iff (reset)
    ret.retire_valid |-> !empty);

endmodule

//--- verilog/free_list.sv
/*
 * circular queue of free physical tags
 * pops at dispatch, pushes retired old tags
 */

`timescale 1ns/1ps
`include "rename_consts.svh"

module free_list (
  input  logic         clock,
  input  logic         reset,
  dispatch_if.allocator alloc,
  retire_if.commit      free,
  output logic         empty
);
  import rename_pkg::*;

  localparam int PTR_W   = $clog2(`FREE_DEPTH);
  localparam int COUNT_W = PTR_W + 1;

  // tag storage
  phys_tag_t queue [`FREE_DEPTH];

  // read and write positions, depth is a power of two so they just wrap
  logic [PTR_W-1:0]   head;
  logic [PTR_W-1:0]   tail;
  logic [COUNT_W-1:0] count;

  logic pop;
  logic push;

  assign pop  = alloc.dispatch_fire;
  assign push = free.retire_valid;

  // head tag offered to the renamer
  assign alloc.new_tag = queue[head];
  assign empty         = (count == '0);

  ////////////////////////////////////////////////////////////////////////////
  // queue update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= COUNT_W'(`FREE_DEPTH);
      // spare tags above the arch range, ascending
      for (int i = 0; i < `FREE_DEPTH; i++) begin
        queue[i] <= phys_tag_t'(`NUM_ARCH_REGS + i);
      end
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (push) begin
        queue[tail] <= free.retire_old_tag;
        tail        <= tail + 1'b1;
      end
      // occupancy
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // retirement never pushes into a full list unless a dispatch pops too
  assert property (@(posedge clock) disable iff (reset)
    push |-> (count < COUNT_W'(`FREE_DEPTH)) || pop);

endmodule

//--- verilog/map_table.sv
/*
 * speculative arch-to-physical map plus per-tag ready bits
 */

`timescale 1ns/1ps
`include "rename_consts.svh"

module map_table (
  input  logic                  clock,
  input  logic                  reset,
  input  rename_pkg::arch_reg_t src_a,
  input  rename_pkg::arch_reg_t src_b,
  output rename_pkg::phys_tag_t src_a_tag,
  output rename_pkg::phys_tag_t src_b_tag,
  output logic                  src_a_ready,
  output logic                  src_b_ready,
  input  logic                  cdb_valid,
  input  rename_pkg::phys_tag_t cdb_tag,
  dispatch_if.renamer           disp
);
  import rename_pkg::*;

  // current speculative mapping, one tag per arch reg
  phys_tag_t map [`NUM_ARCH_REGS];

  // value-ready flag per physical tag
  logic [`NUM_PHYS_REGS-1:0] ready;

  ////////////////////////////////////////////////////////////////////////////
  // lookups, all combinational
  ////////////////////////////////////////////////////////////////////////////

  // source operands
  assign src_a_tag = map[src_a];
  assign src_b_tag = map[src_b];

  // ready bits as of before the edge
  // a cdb strobe this cycle shows up next cycle
  assign src_a_ready = ready[map[src_a]];
  assign src_b_ready = ready[map[src_b]];

  // mapping being replaced goes to the rob as old tag
  assign disp.old_tag = map[disp.dest_arch];

  ////////////////////////////////////////////////////////////////////////////
  // state update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, everything committed and ready
      for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
        map[i] <= phys_tag_t'(i);
      end
      ready <= '1;
    end else begin
      // completion wakes the tag
      if (cdb_valid) begin
        ready[cdb_tag] <= 1'b1;
      end
      // new_tag comes off the free list, never pending,
      // so it cannot collide with the cdb tag above
      if (disp.dispatch_fire) begin
        map[disp.dest_arch] <= disp.new_tag;
        ready[disp.new_tag] <= 1'b0;
      end
    end
  end

  // a dispatch must never hand out a tag that is still live in the map
  assert property (@(posedge clock) disable iff (reset)
    disp.dispatch_fire |-> disp.new_tag != disp.old_tag);

endmodule

//--- verilog/rename_ifs.sv
/*
 * dispatch_if: rename handshake between rob, map table and free list
 * retire_if: head-of-rob retirement to arch map and free list
 */

`timescale 1ns/1ps

interface dispatch_if;
  import rename_pkg::*;

  logic      dispatch_fire;
  arch_reg_t dest_arch;
  phys_tag_t new_tag;
  phys_tag_t old_tag;

  // map table swaps the dest mapping
  modport renamer (input dispatch_fire, input dest_arch, input new_tag, output old_tag);

  // free list hands out the head tag
  modport allocator (input dispatch_fire, output new_tag);

  // rob decides the handshake
  modport tracker (output dispatch_fire);

endinterface

interface retire_if;
  import rename_pkg::*;

  logic      retire_valid;
  arch_reg_t retire_arch;
  phys_tag_t retire_tag;
  phys_tag_t retire_old_tag;

  // driven by the rob head
  modport source (output retire_valid, output retire_arch, output retire_tag,
                  output retire_old_tag);

  // arch map and free list listen
  modport commit (input retire_valid, input retire_arch, input retire_tag,
                  input retire_old_tag);

endinterface

//--- verilog/rename_pkg.sv
/*
 * shared types: register index, physical tag, rob pointer, entry state
 */

`include "rename_consts.svh"

package rename_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // index and tag types
  ////////////////////////////////////////////////////////////////////////////

  // architectural register number
  typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;

  // physical register tag, also what the cdb carries
  typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phys_tag_t;

  // rob pointer, msb is the wrap bit for full/empty
  typedef logic [$clog2(`ROB_DEPTH):0] rob_ptr_t;

  // lifecycle of one rob slot
  typedef enum logic [1:0] {
    ENTRY_FREE    = 2'd0,
    ENTRY_PENDING = 2'd1,
    ENTRY_DONE    = 2'd2
  } rob_state_e;

endpackage

//--- verilog/rename_consts.svh
/*
 * sizing macros for the rename and retirement core
 */

`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// register file sizes
////////////////////////////////////////////////////////////////////////////

// visible architectural registers
`define NUM_ARCH_REGS 8
// physical tags, arch regs plus spares for renaming
`define NUM_PHYS_REGS 16

////////////////////////////////////////////////////////////////////////////
// queue sizes
////////////////////////////////////////////////////////////////////////////

// in-flight instructions
`define ROB_DEPTH 8
// spare tags, physical minus architectural
`define FREE_DEPTH 8

`endif
